// File: hdl/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and address width
`define RV_XLEN 32

// instruction word width
`define RV_INST_W 32

// integer register file
`define RV_REG_COUNT 32
`define RV_REG_INDEX_W 5

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: hdl/rv_pkg.sv
`default_nettype none

`include "rv_cfg.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_REG_INDEX_W-1:0] reg_index_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // LINK is pc + 4 for jal
    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_LINK,
        WB_IMM
    } wb_src_e;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       use_imm;
        reg_index_t rs1;
        reg_index_t rs2;
        reg_index_t rd;
        logic       rd_en;
        wb_src_e    wb_src;
        logic       mem_read;
        logic       mem_write;
        logic       is_branch;
        logic       branch_ne;
        logic       is_jal;
        logic       illegal;
    } ctrl_t;

endpackage

`default_nettype wire

// File: hdl/reg_port_if.sv
`timescale 1ns/100ps
`default_nettype none

interface reg_port_if;
    import rv_pkg::*;

    reg_index_t rs1_index;
    reg_index_t rs2_index;
    word_t      rs1_data;
    word_t      rs2_data;
    logic       wr_en;
    reg_index_t wr_index;
    word_t      wr_data;

    modport core (
        output rs1_index, rs2_index, wr_en, wr_index, wr_data,
        input  rs1_data, rs2_data
    );

    modport file (
        input  rs1_index, rs2_index, wr_en, wr_index, wr_data,
        output rs1_data, rs2_data
    );

endinterface

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_cfg.svh"

module fetch_unit (
    input  wire logic          inst_selfdefine,
    input  wire logic          reset,
    input  wire logic          if_ready,
    input  wire rv_pkg::word_t if_data_read,
    input  wire logic          ls_done,
    input  wire rv_pkg::word_t next_pc,
    output logic               if_valid,
    output rv_pkg::word_t      if_addr,
    output rv_pkg::word_t      inst,
    output rv_pkg::word_t      pc,
    output logic               inst_valid,
    output logic               commit
);
    import rv_pkg::*;

    // wait is only used right after reset
    typedef enum logic [1:0] {
        S_WAIT,
        S_REQ,
        S_EXEC
    } fetch_state_e;

    fetch_state_e state;

    assign if_valid   = (state == S_REQ);
    assign if_addr    = pc;
    assign inst_valid = (state == S_EXEC);
    assign commit     = inst_valid & ls_done;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state <= S_WAIT;
            pc    <= `RV_RESET_PC;
        end else begin
            case (state)
                S_WAIT: state <= S_REQ;
                S_REQ: begin
                    if (if_ready) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    // next fetch starts the cycle after commit
                    if (commit) begin
                        state <= S_REQ;
                        pc    <= next_pc;
                    end
                end
                default: state <= S_WAIT;
            endcase
        end
    end

    // instruction register
    always_ff @(posedge inst_selfdefine) begin
        if (if_valid && if_ready) begin
            inst <= if_data_read;
        end
    end

endmodule

`default_nettype wire

// File: hdl/decoder.sv
`timescale 1ns/100ps
`default_nettype none

module decoder (
    input  wire rv_pkg::word_t inst,
    output rv_pkg::ctrl_t      ctrl,
    output rv_pkg::word_t      imm
);
    import rv_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      i_imm;
    word_t      s_imm;
    word_t      b_imm;
    word_t      u_imm;
    word_t      j_imm;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl     = '0;
        ctrl.rs1 = inst[19:15];
        ctrl.rs2 = inst[24:20];
        ctrl.rd  = inst[11:7];
        imm      = i_imm;

        case (inst[6:0])
            OPC_OP: begin
                ctrl.rd_en  = 1'b1;
                ctrl.wb_src = WB_ALU;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: ctrl.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: ctrl.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: ctrl.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: ctrl.alu_op = ALU_SLT;
                    default: begin
                        ctrl.rd_en   = 1'b0;
                        ctrl.illegal = 1'b1;
                    end
                endcase
            end
            OPC_OP_IMM: begin
                // addi only
                if (funct3 == 3'b000) begin
                    ctrl.alu_op  = ALU_ADD;
                    ctrl.use_imm = 1'b1;
                    ctrl.rd_en   = 1'b1;
                    ctrl.wb_src  = WB_ALU;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            OPC_LUI: begin
                ctrl.rd_en  = 1'b1;
                ctrl.wb_src = WB_IMM;
                imm         = u_imm;
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    ctrl.alu_op   = ALU_ADD;
                    ctrl.use_imm  = 1'b1;
                    ctrl.rd_en    = 1'b1;
                    ctrl.wb_src   = WB_LOAD;
                    ctrl.mem_read = 1'b1;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            OPC_STORE: begin
                imm = s_imm;
                if (funct3 == 3'b010) begin
                    ctrl.alu_op    = ALU_ADD;
                    ctrl.use_imm   = 1'b1;
                    ctrl.mem_write = 1'b1;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            OPC_BRANCH: begin
                imm = b_imm;
                // beq is 000, bne is 001
                if (funct3[2:1] == 2'b00) begin
                    ctrl.is_branch = 1'b1;
                    ctrl.branch_ne = funct3[0];
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            OPC_JAL: begin
                imm         = j_imm;
                ctrl.is_jal = 1'b1;
                ctrl.rd_en  = 1'b1;
                ctrl.wb_src = WB_LINK;
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
    input  wire rv_pkg::ctrl_t ctrl,
    input  wire rv_pkg::word_t imm,
    input  wire rv_pkg::word_t pc,
    input  wire rv_pkg::word_t load_data,
    input  wire logic          commit,
    reg_port_if.core           regs,
    output rv_pkg::word_t      alu_result,
    output rv_pkg::word_t      store_data,
    output rv_pkg::word_t      next_pc
);
    import rv_pkg::*;

    word_t op_a;
    word_t op_b;
    logic  branch_taken;

    assign regs.rs1_index = ctrl.rs1;
    assign regs.rs2_index = ctrl.rs2;

    assign op_a = regs.rs1_data;
    assign op_b = ctrl.use_imm ? imm : regs.rs2_data;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = word_t'($signed(op_a) < $signed(op_b));
            default: alu_result = op_a + op_b;
        endcase
    end

    assign store_data = regs.rs2_data;

    // bne inverts the equality test
    assign branch_taken = ctrl.is_branch & ((regs.rs1_data == regs.rs2_data) ^ ctrl.branch_ne);
    assign next_pc = (branch_taken | ctrl.is_jal) ? pc + imm : pc + 32'd4;

    always_comb begin
        case (ctrl.wb_src)
            WB_ALU:  regs.wr_data = alu_result;
            WB_LOAD: regs.wr_data = load_data;
            WB_LINK: regs.wr_data = pc + 32'd4;
            WB_IMM:  regs.wr_data = imm;
            default: regs.wr_data = alu_result;
        endcase
    end

    assign regs.wr_en    = commit & ctrl.rd_en;
    assign regs.wr_index = ctrl.rd;

endmodule

`default_nettype wire

// File: hdl/regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_cfg.svh"

module regfile (
    input  wire logic inst_selfdefine,
    input  wire logic reset,
    reg_port_if.file  regs
);
    import rv_pkg::*;

    word_t rf [`RV_REG_COUNT];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                rf[i] <= '0;
            end
        end else if (regs.wr_en && (regs.wr_index != '0)) begin
            rf[regs.wr_index] <= regs.wr_data;
        end
    end

    // x0 reads as zero
    assign regs.rs1_data = (regs.rs1_index == '0) ? '0 : rf[regs.rs1_index];
    assign regs.rs2_data = (regs.rs2_index == '0) ? '0 : rf[regs.rs2_index];

endmodule

`default_nettype wire

// File: hdl/load_store_unit.sv
`timescale 1ns/100ps
`default_nettype none

module load_store_unit (
    input  wire logic          inst_selfdefine,
    input  wire logic          reset,
    input  wire rv_pkg::ctrl_t ctrl,
    input  wire logic          inst_valid,
    input  wire rv_pkg::word_t alu_result,
    input  wire rv_pkg::word_t store_data,
    input  wire logic          cpu_mem_ready,
    input  wire rv_pkg::word_t cpu_mem_data_read,
    output logic               cpu_mem_valid,
    output rv_pkg::word_t      cpu_mem_addr,
    output rv_pkg::word_t      cpu_mem_data_write,
    output logic               cpu_mem_req,
    output rv_pkg::word_t      load_data,
    output logic               ls_done
);
    import rv_pkg::*;

    logic  mem_op;
    logic  busy;
    logic  bus_done;

    assign mem_op   = (ctrl.mem_read | ctrl.mem_write) & ~ctrl.illegal;
    assign bus_done = busy & cpu_mem_ready;

    // operands stay put until commit, so the bus fields need no register
    assign cpu_mem_valid      = busy;
    assign cpu_mem_addr       = alu_result;
    assign cpu_mem_data_write = store_data;
    assign cpu_mem_req        = ctrl.mem_write;

    assign ls_done = ~mem_op | bus_done;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (cpu_mem_ready) begin
                busy <= 1'b0;
            end
        end else if (inst_valid && mem_op) begin
            busy <= 1'b1;
        end
    end

    // load result reaches the register file on the ready edge
    assign load_data = cpu_mem_data_read;

endmodule

`default_nettype wire

// File: hdl/cpu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu (
    input  wire logic          inst_selfdefine,
    input  wire logic          reset,

    input  wire logic          if_ready,
    input  wire rv_pkg::word_t if_data_read,
    output logic               if_valid,
    output rv_pkg::word_t      if_addr,

    output logic               cpu_mem_valid,
    input  wire logic          cpu_mem_ready,
    input  wire rv_pkg::word_t cpu_mem_data_read,
    output rv_pkg::word_t      cpu_mem_data_write,
    output rv_pkg::word_t      cpu_mem_addr,
    output logic               cpu_mem_req
);
    import rv_pkg::*;

    word_t inst;
    word_t pc;
    logic  inst_valid;
    logic  commit;
    logic  ls_done;
    word_t next_pc;

    ctrl_t ctrl;
    word_t imm;

    word_t alu_result;
    word_t store_data;
    word_t load_data;

    reg_port_if regs ();

    fetch_unit u_fetch (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .if_ready        (if_ready),
        .if_data_read    (if_data_read),
        .ls_done         (ls_done),
        .next_pc         (next_pc),
        .if_valid        (if_valid),
        .if_addr         (if_addr),
        .inst            (inst),
        .pc              (pc),
        .inst_valid      (inst_valid),
        .commit          (commit)
    );

    decoder u_decoder (
        .inst (inst),
        .ctrl (ctrl),
        .imm  (imm)
    );

    execute_unit u_execute (
        .ctrl       (ctrl),
        .imm        (imm),
        .pc         (pc),
        .load_data  (load_data),
        .commit     (commit),
        .regs       (regs.core),
        .alu_result (alu_result),
        .store_data (store_data),
        .next_pc    (next_pc)
    );

    regfile u_regfile (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .regs            (regs.file)
    );

    load_store_unit u_lsu (
        .inst_selfdefine    (inst_selfdefine),
        .reset              (reset),
        .ctrl               (ctrl),
        .inst_valid         (inst_valid),
        .alu_result         (alu_result),
        .store_data         (store_data),
        .cpu_mem_ready      (cpu_mem_ready),
        .cpu_mem_data_read  (cpu_mem_data_read),
        .cpu_mem_valid      (cpu_mem_valid),
        .cpu_mem_addr       (cpu_mem_addr),
        .cpu_mem_data_write (cpu_mem_data_write),
        .cpu_mem_req        (cpu_mem_req),
        .load_data          (load_data),
        .ls_done            (ls_done)
    );

endmodule

`default_nettype wire

// File: bench/cpu_properties.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_properties (
    input wire logic          inst_selfdefine,
    input wire logic          reset,
    input wire logic          if_valid,
    input wire logic          if_ready,
    input wire rv_pkg::word_t if_addr,
    input wire logic          cpu_mem_valid,
    input wire logic          cpu_mem_ready,
    input wire rv_pkg::word_t cpu_mem_addr,
    input wire rv_pkg::word_t cpu_mem_data_write,
    input wire logic          cpu_mem_req
);

    // number of failed protocol checks
    int error_count = 0;

    // fetch request held until ready
    if_hold: assert property (@(posedge inst_selfdefine) disable iff (reset)
        if_valid && !if_ready |=> if_valid && $stable(if_addr))
        else begin
            $error("instruction request dropped or changed before ready");
            error_count++;
        end

    // data request held until ready
    mem_hold: assert property (@(posedge inst_selfdefine) disable iff (reset)
        cpu_mem_valid && !cpu_mem_ready |=> cpu_mem_valid && $stable(cpu_mem_addr)
            && $stable(cpu_mem_data_write) && $stable(cpu_mem_req))
        else begin
            $error("data request dropped or changed before ready");
            error_count++;
        end

    // one bus at a time
    one_bus: assert property (@(posedge inst_selfdefine) disable iff (reset)
        !(if_valid && cpu_mem_valid))
        else begin
            $error("instruction and data bus active together");
            error_count++;
        end

    // quiet through reset and the cycle after it
    reset_quiet: assert property (@(posedge inst_selfdefine)
        reset |=> !if_valid && !cpu_mem_valid)
        else begin
            $error("bus request raised during or right after reset");
            error_count++;
        end

endmodule

bind cpu cpu_properties u_properties (.*);

`default_nettype wire

// File: bench/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;
    import rv_pkg::*;

    localparam int PROG_LEN = 39;
    localparam int STORE_COUNT = 14;
    localparam int CYCLE_LIMIT = PROG_LEN * 12 + 50;
    localparam word_t HALT_PC = 32'h0000_0098;
    localparam logic [6:0] IMM_OPCODE = 7'b0010011;
    localparam logic [6:0] LOAD_OPCODE = 7'b0000011;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    logic  inst_selfdefine;
    logic  reset;
    logic  if_ready;
    word_t if_data_read;
    logic  if_valid;
    word_t if_addr;
    logic  cpu_mem_valid;
    logic  cpu_mem_ready;
    word_t cpu_mem_data_read;
    word_t cpu_mem_data_write;
    word_t cpu_mem_addr;
    logic  cpu_mem_req;

    word_t  prog [PROG_LEN];
    word_t  dmem [16];
    store_t expected_stores [STORE_COUNT];
    store_t store_q [$];
    integer seed = 32'hf340_6bb1;
    int     if_wait = -1;
    int     mem_wait = -1;
    int     halt_fetches = 0;
    int     stores_checked = 0;
    int     cycle_count = 0;

    cpu uut (.*);

    initial begin
        inst_selfdefine = 1'b0;
        forever #20 inst_selfdefine = ~inst_selfdefine;
    end

    function automatic word_t r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                     input reg_index_t rd, input reg_index_t rs1,
                                     input reg_index_t rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(input logic [6:0] opcode, input logic [2:0] funct3,
                                     input reg_index_t rd, input reg_index_t rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    // sw only
    function automatic word_t s_type(input reg_index_t rs2, input reg_index_t rs1,
                                     input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(input logic [2:0] funct3, input reg_index_t rs1,
                                     input reg_index_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t u_type(input reg_index_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t j_type(input reg_index_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t mem_pattern(input word_t addr);
        return {~addr[15:0] ^ addr[31:16], addr[15:0]};
    endfunction

    // addresses past the program read as a nop
    function automatic word_t program_word(input word_t addr);
        if (addr[31:2] < PROG_LEN) begin
            return prog[addr[31:2]];
        end else begin
            return 32'h0000_0013;
        end
    endfunction

    function automatic int ready_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_addr(input int index, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL at time %0t: store %0d went to 0x%08h, expected 0x%08h",
                                $time, index, actual, expected));
        end
    endtask

    task automatic check_data(input int index, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL at time %0t: store %0d wrote 0x%08h, expected 0x%08h",
                                $time, index, actual, expected));
        end
    endtask

    task automatic load_program();
        prog[0]  = i_type(IMM_OPCODE, 3'b000, 1, 0, 12'd25);
        prog[1]  = i_type(IMM_OPCODE, 3'b000, 2, 0, -7);
        prog[2]  = r_type(7'b0000000, 3'b000, 3, 1, 2);
        prog[3]  = s_type(3, 0, 12'd0);
        prog[4]  = r_type(7'b0100000, 3'b000, 4, 2, 1);
        prog[5]  = s_type(4, 0, 12'd4);
        prog[6]  = i_type(IMM_OPCODE, 3'b000, 5, 0, 12'h06c);
        prog[7]  = i_type(IMM_OPCODE, 3'b000, 6, 0, 12'h03a);
        prog[8]  = r_type(7'b0000000, 3'b111, 7, 5, 6);
        prog[9]  = s_type(7, 0, 12'd8);
        prog[10] = r_type(7'b0000000, 3'b110, 8, 5, 6);
        prog[11] = s_type(8, 0, 12'd12);
        prog[12] = r_type(7'b0000000, 3'b100, 9, 5, 6);
        prog[13] = s_type(9, 0, 12'd16);
        // slt with a negative first and then second operand
        prog[14] = r_type(7'b0000000, 3'b010, 10, 2, 1);
        prog[15] = s_type(10, 0, 12'd20);
        prog[16] = r_type(7'b0000000, 3'b010, 11, 1, 2);
        prog[17] = s_type(11, 0, 12'd24);
        prog[18] = u_type(12, 20'h12345);
        prog[19] = s_type(12, 0, 12'd52);
        prog[20] = i_type(IMM_OPCODE, 3'b000, 12, 12, 12'h678);
        prog[21] = s_type(12, 0, 12'd28);
        prog[22] = i_type(LOAD_OPCODE, 3'b010, 13, 0, 12'd32);
        prog[23] = i_type(IMM_OPCODE, 3'b000, 13, 13, 12'h100);
        prog[24] = s_type(13, 0, 12'd32);
        // taken beq and bne skip the next store
        prog[25] = b_type(3'b000, 1, 1, 13'd8);
        prog[26] = s_type(1, 0, 12'd36);
        prog[27] = b_type(3'b001, 1, 2, 13'd8);
        prog[28] = s_type(2, 0, 12'd36);
        prog[29] = b_type(3'b000, 1, 2, 13'd8);
        prog[30] = s_type(5, 0, 12'd36);
        prog[31] = b_type(3'b001, 1, 1, 13'd8);
        prog[32] = s_type(6, 0, 12'd40);
        prog[33] = j_type(14, 21'd8);
        prog[34] = s_type(0, 0, 12'd44);
        prog[35] = s_type(14, 0, 12'd44);
        prog[36] = i_type(IMM_OPCODE, 3'b000, 0, 0, 12'd99);
        prog[37] = s_type(0, 0, 12'd48);
        prog[38] = j_type(0, 21'd0);
    endtask

    task automatic load_expected();
        expected_stores[0]  = '{32'h0000_0000, 32'h0000_0012};
        expected_stores[1]  = '{32'h0000_0004, 32'hffff_ffe0};
        expected_stores[2]  = '{32'h0000_0008, 32'h0000_0028};
        expected_stores[3]  = '{32'h0000_000c, 32'h0000_007e};
        expected_stores[4]  = '{32'h0000_0010, 32'h0000_0056};
        expected_stores[5]  = '{32'h0000_0014, 32'h0000_0001};
        expected_stores[6]  = '{32'h0000_0018, 32'h0000_0000};
        expected_stores[7]  = '{32'h0000_0034, 32'h1234_5000};
        expected_stores[8]  = '{32'h0000_001c, 32'h1234_5678};
        expected_stores[9]  = '{32'h0000_0020, mem_pattern(32'h0000_0020) + 32'h100};
        expected_stores[10] = '{32'h0000_0024, 32'h0000_006c};
        expected_stores[11] = '{32'h0000_0028, 32'h0000_003a};
        // link of the jal at 0x84
        expected_stores[12] = '{32'h0000_002c, 32'h0000_0088};
        expected_stores[13] = '{32'h0000_0030, 32'h0000_0000};
    endtask

    // instruction and data memory, ready after 0 to 3 cycles
    always @(negedge inst_selfdefine) begin
        if_ready = 1'b0;
        cpu_mem_ready = 1'b0;
        if (!reset && if_valid) begin
            if (if_wait < 0) begin
                if_wait = ready_delay();
            end
            if (if_wait == 0) begin
                if_ready = 1'b1;
                if_data_read = program_word(if_addr);
                if (if_addr == HALT_PC) begin
                    halt_fetches++;
                end
            end
            if_wait--;
        end
        if (!reset && cpu_mem_valid) begin
            if (mem_wait < 0) begin
                mem_wait = ready_delay();
            end
            if (mem_wait == 0) begin
                cpu_mem_ready = 1'b1;
                if (cpu_mem_req) begin
                    dmem[cpu_mem_addr[5:2]] = cpu_mem_data_write;
                    store_q.push_back('{cpu_mem_addr, cpu_mem_data_write});
                end else begin
                    cpu_mem_data_read = dmem[cpu_mem_addr[5:2]];
                end
            end
            mem_wait--;
        end
    end

    // bound bus checker
    always @(posedge inst_selfdefine) begin
        if (uut.u_properties.error_count != 0) begin
            abort_run("bus protocol assertion failed");
        end
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge inst_selfdefine);
            cycle_count++;
        end
        abort_run($sformatf("timeout after %0d cycles: %0d of %0d stores seen, no halt loop",
                            cycle_count, stores_checked, STORE_COUNT));
    end

    initial begin
        store_t got;
        reset = 1'b1;
        if_ready = 1'b0;
        if_data_read = '0;
        cpu_mem_ready = 1'b0;
        cpu_mem_data_read = '0;
        for (int i = 0; i < 16; i++) begin
            dmem[i] = mem_pattern(word_t'(i * 4));
        end
        load_program();
        load_expected();
        repeat (3) @(posedge inst_selfdefine);
        @(negedge inst_selfdefine);
        reset = 1'b0;

        for (int i = 0; i < STORE_COUNT; i++) begin
            while (store_q.size() == 0) begin
                @(posedge inst_selfdefine);
            end
            got = store_q.pop_front();
            check_addr(i, expected_stores[i].addr, got.addr);
            check_data(i, expected_stores[i].data, got.data);
            stores_checked++;
        end

        // halt loop fetched twice, so no later store can be pending
        while (halt_fetches < 2) begin
            @(posedge inst_selfdefine);
        end
        if (store_q.size() != 0) begin
            abort_run($sformatf("unexpected store to address 0x%08h after the last expected one",
                                store_q[0].addr));
        end else if (uut.u_properties.error_count != 0) begin
            abort_run("bus protocol assertion failed");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/reg_port_if.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/execute_unit.sv
hdl/regfile.sv
hdl/load_store_unit.sv
hdl/cpu.sv
bench/cpu_properties.sv
bench/cpu_tb.sv
